//--- vlog.f
+incdir+tb
rtl/tiny_pkg.sv
rtl/reg_file.sv
rtl/tiny_core.sv
rtl/mm_periph.sv
rtl/mm_ram.sv
rtl/tiny_wrapper.sv
tb/tb_tiny_wrapper.sv

//--- Makefile
# Verilator build and run of the tiny core testbench

VERILATOR ?= verilator
TOP       ?= tb_tiny_wrapper
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= STATUS: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- tb/tiny_model.svh
// ====================
// tiny_model: xorshift numbers, random program builders and the ISA reference model
// ====================
`ifndef TINY_MODEL_SVH
`define TINY_MODEL_SVH

// 32-bit xorshift with shifts 13, 17 and 5
function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

function automatic int rand_below(int n);
    return int'(xorshift32() % 32'(n));
endfunction

function automatic logic [31:0] sext16(logic [15:0] v);
    return {{16{v[15]}}, v};
endfunction

// alu layout is opcode, rd, rs, rt, pad, imm
function automatic logic [31:0] enc_alu(logic [3:0] op, int rd, int rs, int rt,
                                        logic [15:0] imm);
    return {op, 3'(rd), 3'(rs), 3'(rt), 3'b000, imm};
endfunction

// memory layout is opcode, base, rt, pad, offset
function automatic logic [31:0] enc_mem(logic [3:0] op, int base, int rt, logic [15:0] offset);
    return {op, 3'(base), 3'(rt), 6'b000000, offset};
endfunction

// store every register into the dump words of the data region
function automatic void add_reg_dump();
    for (int i = 0; i < 8; i++) begin
        prog.push_back(enc_mem(OP_SW, 0, i, 16'(DUMP_BYTE + 4 * i)));
    end
endfunction

// ptr_reg gets 0xF000 as 0x7800 doubled, since a 16-bit immediate sign-extends
function automatic void add_exit_tail(int val_reg, int ptr_reg);
    prog.push_back(enc_alu(OP_ADDI, ptr_reg, 0, 0, 16'h7800));
    prog.push_back(enc_alu(OP_ADD, ptr_reg, ptr_reg, ptr_reg, 16'h0000));
    prog.push_back(enc_mem(OP_SW, ptr_reg, val_reg, 16'(EXIT_ADDR - STDOUT_ADDR)));
    prog.push_back(enc_alu(OP_HALT, 0, 0, 0, 16'h0000));
endfunction

function automatic void build_arith();
    prog.delete();
    for (int i = 0; i < 16; i++) begin
        if (rand_below(2) == 1) begin
            prog.push_back(enc_alu(OP_ADDI, rand_below(8), rand_below(8), 0, 16'(xorshift32())));
        end else begin
            prog.push_back(enc_alu(OP_ADD, rand_below(8), rand_below(8), rand_below(8), 16'h0));
        end
    end
    add_reg_dump();
    add_exit_tail(0, 7);
endfunction

// r1 is the base, set to a random scratch word before each access
function automatic void build_ldst(int pairs);
    int k;
    int j;
    prog.delete();
    for (int r = 2; r < 8; r++) begin
        prog.push_back(enc_alu(OP_ADDI, r, 0, 0, 16'(xorshift32())));
    end
    for (int p = 0; p < pairs; p++) begin
        k = rand_below(64);
        j = rand_below(64);
        prog.push_back(enc_alu(OP_ADDI, 1, 0, 0, 16'(DATA_BYTE + 4 * k)));
        prog.push_back(enc_mem(OP_SW, 1, rand_below(8), 16'(4 * (j - k))));
        k = rand_below(64);
        j = rand_below(64);
        prog.push_back(enc_alu(OP_ADDI, 1, 0, 0, 16'(DATA_BYTE + 4 * k)));
        prog.push_back(enc_mem(OP_LW, 1, 2 + rand_below(6), 16'(4 * (j - k))));
    end
    add_reg_dump();
    add_exit_tail(0, 7);
endfunction

// r2 counts down, r3 points at stdout, r4 holds the next character
function automatic void build_loop(int count, int char0);
    prog.delete();
    prog.push_back(enc_alu(OP_ADDI, 2, 0, 0, 16'(count)));
    prog.push_back(enc_alu(OP_ADDI, 3, 0, 0, 16'h7800));
    prog.push_back(enc_alu(OP_ADD, 3, 3, 3, 16'h0000));
    prog.push_back(enc_alu(OP_ADDI, 4, 0, 0, 16'(char0)));
    prog.push_back(enc_mem(OP_SW, 3, 4, 16'h0000));
    prog.push_back(enc_alu(OP_ADDI, 4, 4, 0, 16'h0001));
    prog.push_back(enc_alu(OP_ADDI, 2, 2, 0, 16'hFFFF));
    prog.push_back(enc_mem(OP_BNEZ, 0, 2, 16'hFFFD));
    prog.push_back(enc_mem(OP_SW, 3, 0, 16'(EXIT_ADDR - STDOUT_ADDR)));
    prog.push_back(enc_alu(OP_HALT, 0, 0, 0, 16'h0000));
endfunction

// two exit stores, only the first may count
function automatic void build_exit(logic [15:0] first, logic [15:0] second);
    prog.delete();
    prog.push_back(enc_alu(OP_ADDI, 5, 0, 0, first));
    prog.push_back(enc_alu(OP_ADDI, 6, 0, 0, second));
    prog.push_back(enc_alu(OP_ADDI, 7, 0, 0, 16'h7800));
    prog.push_back(enc_alu(OP_ADD, 7, 7, 7, 16'h0000));
    prog.push_back(enc_mem(OP_SW, 7, 5, 16'(EXIT_ADDR - STDOUT_ADDR)));
    prog.push_back(enc_mem(OP_SW, 7, 6, 16'(EXIT_ADDR - STDOUT_ADDR)));
    prog.push_back(enc_alu(OP_HALT, 0, 0, 0, 16'h0000));
endfunction

function automatic void set_reg(logic [2:0] idx, logic [31:0] val);
    if (idx != 3'd0) begin
        model_regs[idx] = val;
    end
endfunction

// runs the loaded program on the model registers and memory image
function automatic void execute_program();
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] addr;
    logic [3:0]  op;
    bit          running;
    int          steps;
    for (int i = 0; i < 8; i++) begin
        model_regs[i] = 32'h0;
    end
    model_chars.delete();
    model_exit_valid = 1'b0;
    model_exit_value = 32'h0;
    pc = BOOT_ADDR;
    running = 1'b1;
    steps = 0;
    while (running && (steps < MAX_STEPS)) begin
        ins = model_mem[pc[RAM_AW+1:2]];
        op = ins[31:28];
        addr = model_regs[ins[27:25]] + sext16(ins[15:0]);
        steps++;
        case (op)
            OP_ADDI: set_reg(ins[27:25], model_regs[ins[24:22]] + sext16(ins[15:0]));
            OP_ADD:  set_reg(ins[27:25], model_regs[ins[24:22]] + model_regs[ins[21:19]]);
            OP_LW: begin
                // the peripheral region answers loads with zero
                if (addr[15:12] == 4'hF) begin
                    set_reg(ins[24:22], 32'h0);
                end else begin
                    set_reg(ins[24:22], model_mem[addr[RAM_AW+1:2]]);
                end
            end
            OP_SW: begin
                if (addr[15:12] != 4'hF) begin
                    model_mem[addr[RAM_AW+1:2]] = model_regs[ins[24:22]];
                end else if (addr[31:2] == STDOUT_ADDR[31:2]) begin
                    model_chars.push_back(model_regs[ins[24:22]][7:0]);
                end else if ((addr[31:2] == EXIT_ADDR[31:2]) && !model_exit_valid) begin
                    model_exit_valid = 1'b1;
                    model_exit_value = model_regs[ins[24:22]];
                end
            end
            OP_BNEZ: begin
                if (model_regs[ins[24:22]] != 32'h0) begin
                    addr = sext16(ins[15:0]);
                    pc = pc + {addr[29:0], 2'b00} - 32'd4;
                end
            end
            default: running = 1'b0;
        endcase
        pc = pc + 32'd4;
    end
    model_steps = steps;
    model_halted = !running;
endfunction

`endif

//--- tb/tb_tiny_wrapper.sv
// ====================
// tb_tiny_wrapper: loads random programs over Wishbone and checks each run
// against the reference model
// ====================
`default_nettype none

module tb_tiny_wrapper;
    import tiny_pkg::*;

    localparam int          RAM_AW     = 10;
    localparam int          RAM_WORDS  = 2 ** RAM_AW;
    localparam logic [31:0] BOOT_ADDR  = 32'h0000_0000;
    localparam int          DATA_WORD0 = 256;
    localparam int          DATA_WORDS = 128;
    localparam int          DATA_BYTE  = DATA_WORD0 * 4;
    // scratch stores use the first 64 words, register dumps sit at word 112
    localparam int          DUMP_BYTE  = DATA_BYTE + 4 * 112;
    localparam int          MAX_STEPS  = 4000;
    localparam logic [31:0] SEED       = 32'd21;

    logic        clk;
    logic        arst_n;
    logic        fetch_enable;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat;
    logic [31:0] wb_dat_o;
    logic        wb_ack;
    logic        stdout_valid_o;
    logic [7:0]  stdout_char_o;
    logic        exit_valid_o;
    logic [31:0] exit_value_o;
    logic        tests_passed_o;
    logic        tests_failed_o;
    logic        halted_o;

    logic [31:0] rng_state;
    logic [31:0] prog [$];
    logic [31:0] model_regs [8];
    logic [31:0] model_mem [RAM_WORDS];
    logic [7:0]  model_chars [$];
    bit          model_exit_valid;
    logic [31:0] model_exit_value;
    int          model_steps;
    bit          model_halted;
    logic [7:0]  dut_chars [$];
    bit          dut_exit_seen;
    logic [31:0] dut_first_exit;
    int          value_errors;
    int          protocol_errors;
    int          budget;
    int          cycles;

    `include "tiny_model.svh"

    tiny_wrapper #(
        .RAM_ADDR_WIDTH (RAM_AW),
        .BOOT_ADDR      (BOOT_ADDR)
    ) u_tiny_wrapper (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .fetch_enable_i (fetch_enable),
        .wb_cyc_i       (wb_cyc),
        .wb_stb_i       (wb_stb),
        .wb_we_i        (wb_we),
        .wb_adr_i       (wb_adr),
        .wb_dat_i       (wb_dat),
        .wb_dat_o       (wb_dat_o),
        .wb_ack_o       (wb_ack),
        .stdout_valid_o (stdout_valid_o),
        .stdout_char_o  (stdout_char_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .halted_o       (halted_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // the budget grows with every bus access, reset and modeled instruction
    initial begin
        cycles = 0;
        budget = 2000;
        while (cycles <= budget) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR: watchdog expired after %0d cycles, the DUT stopped responding", cycles);
        $display("errors: %0d value, %0d protocol, 1 timeout", value_errors, protocol_errors);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic compare_word(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
        assert (got === exp) else begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic apply_reset();
        arst_n = 1'b0;
        fetch_enable = 1'b0;
        budget += 10;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
    endtask

    // one Wishbone classic cycle, held until ack, then ack must drop
    task automatic bus_access(input bit we, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        budget += 6;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = addr;
        wb_dat = wdata;
        @(posedge clk);
        #1;
        while (!wb_ack) begin
            @(posedge clk);
            #1;
        end
        rdata = wb_dat_o;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        @(posedge clk);
        #1;
        assert (!wb_ack) else begin
            protocol_errors++;
            $display("ERROR at %0t: Wishbone ack stayed high for more than one cycle", $time);
        end
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(1'b1, addr, data, unused);
        model_mem[addr[RAM_AW+1:2]] = data;
    endtask

    task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
        bus_access(1'b0, addr, 32'h0, data);
    endtask

    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            write_word(32'(i * 4) + BOOT_ADDR, prog[i]);
        end
    endtask

    task automatic run_on_dut();
        dut_chars.delete();
        dut_exit_seen = 1'b0;
        dut_first_exit = 32'h0;
        fetch_enable = 1'b1;
        while (!halted_o) begin
            @(posedge clk);
            #1;
            if (stdout_valid_o) begin
                dut_chars.push_back(stdout_char_o);
            end
            if (exit_valid_o && !dut_exit_seen) begin
                dut_exit_seen = 1'b1;
                dut_first_exit = exit_value_o;
            end
        end
        fetch_enable = 1'b0;
    endtask

    task automatic check_results();
        logic [31:0] got;
        int          n;
        compare_word(32'(dut_chars.size()), 32'(model_chars.size()), "stdout character count");
        n = (dut_chars.size() < model_chars.size()) ? dut_chars.size() : model_chars.size();
        for (int i = 0; i < n; i++) begin
            compare_word({24'h0, dut_chars[i]}, {24'h0, model_chars[i]},
                         $sformatf("stdout character %0d", i));
        end
        @(posedge clk);
        #1;
        compare_word({31'h0, halted_o}, {31'h0, model_halted}, "halted_o after HALT");
        compare_word({31'h0, dut_exit_seen}, {31'h0, model_exit_valid}, "exit_valid_o");
        if (model_exit_valid) begin
            compare_word(dut_first_exit, model_exit_value, "exit_value_o at first exit");
            compare_word(exit_value_o, model_exit_value, "exit_value_o at end of run");
            compare_word({31'h0, tests_passed_o}, {31'h0, model_exit_value == 32'h0},
                         "tests_passed_o");
            compare_word({31'h0, tests_failed_o}, {31'h0, model_exit_value != 32'h0},
                         "tests_failed_o");
        end
        for (int w = 0; w < DATA_WORDS; w++) begin
            read_word(32'((DATA_WORD0 + w) * 4), got);
            compare_word(got, model_mem[DATA_WORD0 + w], $sformatf("data word %0d", w));
        end
    endtask

    task automatic run_case();
        apply_reset();
        load_program();
        execute_program();
        budget += 40 * model_steps;
        run_on_dut();
        check_results();
    endtask

    initial begin
        logic [31:0] addr_q [$];
        logic [31:0] addr;
        logic [31:0] got;
        logic [15:0] first;
        int          count;
        rng_state = SEED;
        value_errors = 0;
        protocol_errors = 0;
        arst_n = 1'b0;
        fetch_enable = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = 32'h0;
        wb_dat = 32'h0;
        apply_reset();

        // Wishbone writes to random words, then readback of each
        for (int k = 0; k < 40; k++) begin
            addr = 32'(rand_below(RAM_WORDS) * 4);
            write_word(addr, xorshift32());
            addr_q.push_back(addr);
        end
        foreach (addr_q[i]) begin
            read_word(addr_q[i], got);
            compare_word(got, model_mem[addr_q[i][RAM_AW+1:2]],
                         $sformatf("readback of address %h", addr_q[i]));
        end
        for (int w = 0; w < DATA_WORDS; w++) begin
            write_word(32'((DATA_WORD0 + w) * 4), xorshift32());
        end

        repeat (3) begin
            build_arith();
            run_case();
            read_word(32'(DUMP_BYTE), got);
            compare_word(got, 32'h0, "dumped register 0");
        end
        repeat (3) begin
            build_ldst(12);
            run_case();
        end
        repeat (3) begin
            count = 1 + rand_below(12);
            build_loop(count, 8'h41 + rand_below(20));
            run_case();
            compare_word(32'(dut_chars.size()), 32'(count), "stdout pulses of the loop");
        end
        repeat (4) begin
            first = (rand_below(2) == 1) ? 16'(xorshift32()) : 16'h0000;
            build_exit(first, 16'(xorshift32()) | 16'h0001);
            run_case();
        end

        $display("errors: %0d value, %0d protocol, 0 timeout", value_errors, protocol_errors);
        if ((value_errors + protocol_errors) == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/tiny_wrapper.sv
// ====================
// tiny_wrapper: tiny core joined to its RAM and pseudo-peripherals
// ====================
`default_nettype none

module tiny_wrapper #(
    parameter int unsigned RAM_ADDR_WIDTH = 10,
    parameter logic [31:0] BOOT_ADDR      = 32'h0000_0000
) (
    input  wire logic        clk_i,
    input  wire logic        arst_n_i,
    input  wire logic        fetch_enable_i,

    input  wire logic        wb_cyc_i,
    input  wire logic        wb_stb_i,
    input  wire logic        wb_we_i,
    input  wire logic [31:0] wb_adr_i,
    input  wire logic [31:0] wb_dat_i,
    output logic      [31:0] wb_dat_o,
    output logic             wb_ack_o,

    output logic             stdout_valid_o,
    output logic      [7:0]  stdout_char_o,
    output logic             exit_valid_o,
    output logic      [31:0] exit_value_o,
    output logic             tests_passed_o,
    output logic             tests_failed_o,
    output logic             halted_o
);

    // instruction port
    logic        instr_req;
    logic        instr_gnt;
    logic        instr_rvalid;
    logic [31:0] instr_addr;
    logic [31:0] instr_rdata;

    // data port
    logic        data_req;
    logic        data_gnt;
    logic        data_rvalid;
    logic [31:0] data_addr;
    logic        data_we;
    logic [31:0] data_wdata;
    logic [31:0] data_rdata;

    tiny_core #(
        .BOOT_ADDR (BOOT_ADDR)
    ) u_tiny_core (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .fetch_enable_i (fetch_enable_i),
        .instr_req_o    (instr_req),
        .instr_addr_o   (instr_addr),
        .instr_gnt_i    (instr_gnt),
        .instr_rvalid_i (instr_rvalid),
        .instr_rdata_i  (instr_rdata),
        .data_req_o     (data_req),
        .data_addr_o    (data_addr),
        .data_we_o      (data_we),
        .data_wdata_o   (data_wdata),
        .data_gnt_i     (data_gnt),
        .data_rvalid_i  (data_rvalid),
        .data_rdata_i   (data_rdata),
        .halted_o       (halted_o)
    );

    mm_ram #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) u_mm_ram (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .instr_req_i    (instr_req),
        .instr_addr_i   (instr_addr),
        .instr_gnt_o    (instr_gnt),
        .instr_rvalid_o (instr_rvalid),
        .instr_rdata_o  (instr_rdata),
        .data_req_i     (data_req),
        .data_addr_i    (data_addr),
        .data_we_i      (data_we),
        .data_wdata_i   (data_wdata),
        .data_gnt_o     (data_gnt),
        .data_rvalid_o  (data_rvalid),
        .data_rdata_o   (data_rdata),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_we_i        (wb_we_i),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_dat_o       (wb_dat_o),
        .wb_ack_o       (wb_ack_o),
        .stdout_valid_o (stdout_valid_o),
        .stdout_char_o  (stdout_char_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o)
    );

endmodule

`default_nettype wire

//--- rtl/mm_ram.sv
// ====================
// mm_ram: dual-port RAM for the core and Wishbone host, plus peripheral decode
// ====================
`default_nettype none

module mm_ram #(
    parameter int unsigned RAM_ADDR_WIDTH = 10
) (
    input  wire logic        clk_i,
    input  wire logic        arst_n_i,

    input  wire logic        instr_req_i,
    input  wire logic [31:0] instr_addr_i,
    output logic             instr_gnt_o,
    output logic             instr_rvalid_o,
    output logic      [31:0] instr_rdata_o,

    input  wire logic        data_req_i,
    input  wire logic [31:0] data_addr_i,
    input  wire logic        data_we_i,
    input  wire logic [31:0] data_wdata_i,
    output logic             data_gnt_o,
    output logic             data_rvalid_o,
    output logic      [31:0] data_rdata_o,

    input  wire logic        wb_cyc_i,
    input  wire logic        wb_stb_i,
    input  wire logic        wb_we_i,
    input  wire logic [31:0] wb_adr_i,
    input  wire logic [31:0] wb_dat_i,
    output logic      [31:0] wb_dat_o,
    output logic             wb_ack_o,

    output logic             stdout_valid_o,
    output logic      [7:0]  stdout_char_o,
    output logic             exit_valid_o,
    output logic      [31:0] exit_value_o,
    output logic             tests_passed_o,
    output logic             tests_failed_o
);
    import tiny_pkg::*;

    localparam int unsigned RAM_WORDS = 2 ** RAM_ADDR_WIDTH;

    logic [31:0]               mem [RAM_WORDS];
    logic                      data_periph;
    logic                      host_accept;
    logic [RAM_ADDR_WIDTH-1:0] portb_word;
    logic                      portb_we;
    logic [31:0]               portb_wdata;
    logic [31:0]               portb_rdata_q;
    logic                      data_zero_q;

    assign data_periph = (data_addr_i[15:12] == PERIPH_PAGE);

    // the core is never stalled; the host takes port B only in idle cycles
    // and not again while its ack is out
    assign instr_gnt_o = instr_req_i;
    assign data_gnt_o  = data_req_i;
    assign host_accept = wb_cyc_i && wb_stb_i && !data_req_i && !wb_ack_o;

    assign portb_word  = data_req_i ? data_addr_i[RAM_ADDR_WIDTH+1:2]
                                    : wb_adr_i[RAM_ADDR_WIDTH+1:2];
    assign portb_we    = data_req_i ? (data_we_i && !data_periph) : (host_accept && wb_we_i);
    assign portb_wdata = data_req_i ? data_wdata_i : wb_dat_i;

    // port A, instruction fetch
    always_ff @(posedge clk_i) begin
        if (instr_req_i) begin
            instr_rdata_o <= mem[instr_addr_i[RAM_ADDR_WIDTH+1:2]];
        end
    end

    // port B, shared by core data and host
    always_ff @(posedge clk_i) begin
        if (portb_we) begin
            mem[portb_word] <= portb_wdata;
        end
        if (data_req_i || host_accept) begin
            portb_rdata_q <= mem[portb_word];
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            instr_rvalid_o <= 1'b0;
            data_rvalid_o  <= 1'b0;
            data_zero_q    <= 1'b0;
            wb_ack_o       <= 1'b0;
        end else begin
            instr_rvalid_o <= instr_req_i;
            data_rvalid_o  <= data_req_i;
            data_zero_q    <= data_req_i && (data_we_i || data_periph);
            wb_ack_o       <= host_accept;
        end
    end

    // writes and peripheral accesses answer with zero data
    assign data_rdata_o = data_zero_q ? 32'h0 : portb_rdata_q;
    assign wb_dat_o     = portb_rdata_q;

    mm_periph u_mm_periph (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .wr_i           (data_req_i && data_we_i && data_periph),
        .addr_i         (data_addr_i),
        .wdata_i        (data_wdata_i),
        .stdout_valid_o (stdout_valid_o),
        .stdout_char_o  (stdout_char_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o)
    );

endmodule

`default_nettype wire

//--- rtl/mm_periph.sv
// ====================
// mm_periph: stdout character port and the exit/status register
// ====================
`default_nettype none

module mm_periph (
    input  wire logic        clk_i,
    input  wire logic        arst_n_i,
    input  wire logic        wr_i,
    input  wire logic [31:0] addr_i,
    input  wire logic [31:0] wdata_i,
    output logic             stdout_valid_o,
    output logic      [7:0]  stdout_char_o,
    output logic             exit_valid_o,
    output logic      [31:0] exit_value_o,
    output logic             tests_passed_o,
    output logic             tests_failed_o
);
    import tiny_pkg::*;

    logic stdout_wr;
    logic exit_wr;

    // word addresses only, the byte offset is ignored
    assign stdout_wr = wr_i && (addr_i[31:2] == STDOUT_ADDR[31:2]);
    assign exit_wr   = wr_i && (addr_i[31:2] == EXIT_ADDR[31:2]);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stdout_valid_o <= 1'b0;
            exit_valid_o   <= 1'b0;
            exit_value_o   <= 32'h0;
        end else begin
            stdout_valid_o <= stdout_wr;
            // only the first exit store counts
            if (exit_wr && !exit_valid_o) begin
                exit_valid_o <= 1'b1;
                exit_value_o <= wdata_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (stdout_wr) begin
            stdout_char_o <= wdata_i[7:0];
        end
    end

    assign tests_passed_o = exit_valid_o && (exit_value_o == 32'h0);
    assign tests_failed_o = exit_valid_o && (exit_value_o != 32'h0);

endmodule

`default_nettype wire

//--- rtl/tiny_core.sv
// ====================
// tiny_core: multi-cycle core for the six-instruction word ISA,
// with separate instruction and data request ports
// ====================
`default_nettype none

module tiny_core #(
    parameter logic [31:0] BOOT_ADDR = 32'h0000_0000
) (
    input  wire logic        clk_i,
    input  wire logic        arst_n_i,
    input  wire logic        fetch_enable_i,

    output logic             instr_req_o,
    output logic      [31:0] instr_addr_o,
    input  wire logic        instr_gnt_i,
    input  wire logic        instr_rvalid_i,
    input  wire logic [31:0] instr_rdata_i,

    output logic             data_req_o,
    output logic      [31:0] data_addr_o,
    output logic             data_we_o,
    output logic      [31:0] data_wdata_o,
    input  wire logic        data_gnt_i,
    input  wire logic        data_rvalid_i,
    input  wire logic [31:0] data_rdata_i,

    output logic             halted_o
);
    import tiny_pkg::*;

    localparam logic [2:0] S_IDLE       = 3'd0;
    localparam logic [2:0] S_FETCH_REQ  = 3'd1;
    localparam logic [2:0] S_FETCH_WAIT = 3'd2;
    localparam logic [2:0] S_EXEC       = 3'd3;
    localparam logic [2:0] S_DATA_REQ   = 3'd4;
    localparam logic [2:0] S_DATA_WAIT  = 3'd5;
    localparam logic [2:0] S_HALTED     = 3'd6;

    logic [2:0]  state_q, state_d;
    logic [31:0] pc_q, pc_d;
    instr_u      instr_q;
    opcode_e     opcode;
    logic        is_mem_fmt;
    logic [2:0]  next_fetch;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_imm;
    logic [31:0] mem_offset;
    logic [31:0] alu_result;
    logic        rf_we;
    logic [2:0]  rf_waddr;
    logic [31:0] rf_wdata;

    assign opcode     = instr_q.alu.opcode;
    assign is_mem_fmt = (opcode == OP_LW) || (opcode == OP_SW) || (opcode == OP_BNEZ);

    // operand a is rs or base, operand b is rt in either layout
    reg_file u_reg_file (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .raddr_a_i (is_mem_fmt ? instr_q.mem.base : instr_q.alu.rs),
        .raddr_b_i (is_mem_fmt ? instr_q.mem.rt : instr_q.alu.rt),
        .rdata_a_o (op_a),
        .rdata_b_o (op_b),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata)
    );

    assign alu_imm    = {{16{instr_q.alu.imm[15]}}, instr_q.alu.imm};
    assign mem_offset = {{16{instr_q.mem.offset[15]}}, instr_q.mem.offset};
    assign alu_result = op_a + ((opcode == OP_ADD) ? op_b : alu_imm);

    // arithmetic retires in execute, a load when its data comes back
    assign rf_we    = ((state_q == S_EXEC) && ((opcode == OP_ADDI) || (opcode == OP_ADD))) ||
                      ((state_q == S_DATA_WAIT) && data_rvalid_i && (opcode == OP_LW));
    assign rf_waddr = (opcode == OP_LW) ? instr_q.mem.rt : instr_q.alu.rd;
    assign rf_wdata = (opcode == OP_LW) ? data_rdata_i : alu_result;

    // operands come straight from the register file, which holds still
    // while a data request waits for its grant
    assign data_req_o   = (state_q == S_DATA_REQ);
    assign data_addr_o  = op_a + mem_offset;
    assign data_we_o    = (opcode == OP_SW);
    assign data_wdata_o = op_b;

    assign instr_req_o  = (state_q == S_FETCH_REQ);
    assign instr_addr_o = pc_q;
    assign halted_o     = (state_q == S_HALTED);

    assign next_fetch = fetch_enable_i ? S_FETCH_REQ : S_IDLE;

    always_comb begin
        state_d = state_q;
        pc_d    = pc_q;
        case (state_q)
            S_IDLE: begin
                if (fetch_enable_i) begin
                    state_d = S_FETCH_REQ;
                end
            end
            S_FETCH_REQ: begin
                if (instr_gnt_i) begin
                    state_d = S_FETCH_WAIT;
                end
            end
            S_FETCH_WAIT: begin
                if (instr_rvalid_i) begin
                    state_d = S_EXEC;
                end
            end
            S_EXEC: begin
                case (opcode)
                    OP_ADDI, OP_ADD: begin
                        pc_d    = pc_q + 32'd4;
                        state_d = next_fetch;
                    end
                    OP_LW, OP_SW: begin
                        state_d = S_DATA_REQ;
                    end
                    OP_BNEZ: begin
                        // offset counts words from this instruction
                        pc_d    = (op_b != 32'h0) ? pc_q + {mem_offset[29:0], 2'b00}
                                                  : pc_q + 32'd4;
                        state_d = next_fetch;
                    end
                    default: begin
                        state_d = S_HALTED;
                    end
                endcase
            end
            S_DATA_REQ: begin
                if (data_gnt_i) begin
                    state_d = S_DATA_WAIT;
                end
            end
            S_DATA_WAIT: begin
                if (data_rvalid_i) begin
                    pc_d    = pc_q + 32'd4;
                    state_d = next_fetch;
                end
            end
            S_HALTED: begin
                state_d = S_HALTED;
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_IDLE;
            pc_q    <= BOOT_ADDR;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == S_FETCH_WAIT) && instr_rvalid_i) begin
            instr_q <= instr_rdata_i;
        end
    end

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
// ====================
// reg_file: eight 32-bit registers, two read ports and one write port
// ====================
`default_nettype none

module reg_file (
    input  wire logic        clk_i,
    input  wire logic        arst_n_i,
    input  wire logic [2:0]  raddr_a_i,
    input  wire logic [2:0]  raddr_b_i,
    output logic      [31:0] rdata_a_o,
    output logic      [31:0] rdata_b_o,
    input  wire logic        we_i,
    input  wire logic [2:0]  waddr_i,
    input  wire logic [31:0] wdata_i
);

    logic [7:0][31:0] regs_q;

    // register 0 is never written, so it keeps its reset value of zero
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            regs_q <= '0;
        end else if (we_i && (waddr_i != 3'd0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    assign rdata_a_o = (raddr_a_i == 3'd0) ? 32'h0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == 3'd0) ? 32'h0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

//--- rtl/tiny_pkg.sv
// ====================
// tiny_pkg: opcodes, instruction layouts and peripheral map of the tiny core
// ====================
`default_nettype none

package tiny_pkg;

    // opcode lives in the top nibble of every instruction
    // code zero halts, so an unloaded word stops the core
    typedef enum logic [3:0] {
        OP_HALT = 4'h0,
        OP_ADDI = 4'h1,
        OP_ADD  = 4'h2,
        OP_LW   = 4'h3,
        OP_SW   = 4'h4,
        OP_BNEZ = 4'h5
    } opcode_e;

    // register to register and register to immediate arithmetic
    typedef struct packed {
        opcode_e     opcode;
        logic [2:0]  rd;
        logic [2:0]  rs;
        logic [2:0]  rt;
        logic [2:0]  pad;
        logic [15:0] imm;
    } alu_fmt_t;

    // loads, stores and the conditional branch
    typedef struct packed {
        opcode_e     opcode;
        logic [2:0]  base;
        logic [2:0]  rt;
        logic [5:0]  pad;
        logic [15:0] offset;
    } mem_fmt_t;

    typedef union packed {
        alu_fmt_t alu;
        mem_fmt_t mem;
    } instr_u;

    localparam logic [31:0] STDOUT_ADDR = 32'h0000_F000;
    localparam logic [31:0] EXIT_ADDR   = 32'h0000_F004;

    // value of address bits 15:12 that selects the peripheral region
    localparam logic [3:0]  PERIPH_PAGE = 4'hF;

endpackage

`default_nettype wire
